/* mex_settings.svh */
`ifndef MEX_SETTINGS_SVH
`define MEX_SETTINGS_SVH

// number of queued latches between mem and ex
`define MEX_Q_LENGTH 8

// width of one operand value
`define MEX_OP_WIDTH 32

// operands carried per instruction
`define MEX_NUM_OPS 4

// producer tag width on the result broadcast
`define MEX_TAG_WIDTH 6

// head and tail pointer width
`define MEX_PTR_WIDTH $clog2(`MEX_Q_LENGTH)

`endif

/* mex_pkg.sv */
`include "mex_settings.svh"

package mex_pkg;

    // control fields written once by mem, never touched again
    typedef struct packed {
        // fetch address of the instruction
        logic [31:0] eip;
        // pending exception and its cause
        logic ie;
        logic [3:0] ie_type;
        // branch prediction made at fetch
        logic [31:0] br_pred_target;
        logic br_pred_taken;
        // operand size code
        logic [1:0] opsize;
        // alu operation and adder input selector
        logic [4:0] aluk;
        logic [2:0] mux_adder;
        logic is_br;
        logic is_fp;
        // code segment selector
        logic [15:0] cs;
        // producer tag per operand, compared against broadcasts
        logic [`MEX_NUM_OPS-1:0][`MEX_TAG_WIDTH-1:0] src_tag;
    } mex_fixed_t;

    // fields a result broadcast may still fill in
    typedef struct packed {
        // one bit per operand, set once its value is present
        logic [`MEX_NUM_OPS-1:0] wake;
        logic [`MEX_NUM_OPS-1:0][`MEX_OP_WIDTH-1:0] op_val;
    } mex_mod_t;

    // one whole latch, fixed part first
    typedef struct packed {
        mex_fixed_t fixed;
        mex_mod_t modif;
    } mex_entry_t;

    // result forwarded from a later stage
    typedef struct packed {
        logic valid;
        logic [`MEX_TAG_WIDTH-1:0] tag;
        logic [`MEX_OP_WIDTH-1:0] value;
    } mex_bcast_t;

    // what each slot reports to the head mux
    typedef struct packed {
        logic occupied;
        mex_entry_t entry;
    } mex_slot_stat_t;

endpackage

/* mex_queue_ctrl.sv */
`timescale 1ns/1ps
`include "mex_settings.svh"

module mex_queue_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          wr,
    input  logic                          rd,
    input  logic                          clr,
    output logic                          full,
    output logic                          empty,
    output logic [`MEX_Q_LENGTH-1:0]      slot_wr,
    output logic [`MEX_Q_LENGTH-1:0]      slot_pop,
    output logic                          slot_clr,
    output logic [`MEX_PTR_WIDTH-1:0]     head_ptr
);

    localparam int unsigned PW = `MEX_PTR_WIDTH;
    localparam logic [PW-1:0] LAST_SLOT = PW'(`MEX_Q_LENGTH - 1);
    localparam logic [PW:0] DEPTH = (PW + 1)'(`MEX_Q_LENGTH);
    localparam logic [`MEX_Q_LENGTH-1:0] ONE_HOT_0 = `MEX_Q_LENGTH'(1);

    // slot the next accepted write lands in
    logic [PW-1:0] tail_ptr;
    // entries held, one bit wider so a full queue is distinct
    logic [PW:0] count;
    logic wr_acc;
    logic rd_acc;

    // wrap explicitly, depth need not be a power of two
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        if (p == LAST_SLOT) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full  = (count == DEPTH);
    assign empty = (count == '0);

    // a write into a full queue is dropped even with rd high
    assign wr_acc = wr && !full;
    assign rd_acc = rd && !empty;

    // one-hot strobes toward the slots
    assign slot_wr  = wr_acc ? (ONE_HOT_0 << tail_ptr) : '0;
    assign slot_pop = rd_acc ? (ONE_HOT_0 << head_ptr) : '0;
    // slots give clr priority over their own write and pop
    assign slot_clr = clr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
        end else if (clr) begin
            // clr beats any wr or rd in the same cycle
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
        end else begin
            if (wr_acc) begin
                tail_ptr <= ptr_inc(tail_ptr);
            end
            if (rd_acc) begin
                head_ptr <= ptr_inc(head_ptr);
            end
            // simultaneous push and pop leaves the count alone
            case ({wr_acc, rd_acc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* mex_latch_slot.sv */
`timescale 1ns/1ps
`include "mex_settings.svh"

module mex_latch_slot import mex_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           wr_en,
    input  logic           pop,
    input  logic           clr,
    input  mex_entry_t     din,
    input  mex_bcast_t     bcast,
    output mex_slot_stat_t stat
);

    logic occupied;
    // stored latch, payload only
    mex_entry_t entry;
    // incoming entry with the current broadcast already applied
    mex_mod_t din_merged;
    // stored operands with the current broadcast applied
    mex_mod_t held_merged;

    // apply one broadcast to a set of operands
    // only a waiting operand whose tag matches takes the value
    function automatic mex_mod_t bcast_merge(input mex_mod_t m,
                                             input mex_fixed_t f,
                                             input mex_bcast_t b);
        mex_mod_t r;
        r = m;
        for (int i = 0; i < `MEX_NUM_OPS; i++) begin
            if (b.valid && !m.wake[i] && (f.src_tag[i] == b.tag)) begin
                r.op_val[i] = b.value;
                r.wake[i]   = 1'b1;
            end
        end
        return r;
    endfunction

    assign din_merged  = bcast_merge(din.modif, din.fixed, bcast);
    assign held_merged = bcast_merge(entry.modif, entry.fixed, bcast);

    // occupancy, clr first, then write, then pop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupied <= 1'b0;
        end else if (clr) begin
            occupied <= 1'b0;
        end else if (wr_en) begin
            occupied <= 1'b1;
        end else if (pop) begin
            occupied <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            // same-edge broadcast lands in the new entry
            entry.fixed <= din.fixed;
            entry.modif <= din_merged;
        end else if (occupied) begin
            // waiting entry keeps snooping the broadcast
            entry.modif <= held_merged;
        end
    end

    assign stat.occupied = occupied;
    assign stat.entry    = entry;

endmodule

/* mex_head_select.sv */
`timescale 1ns/1ps
`include "mex_settings.svh"

module mex_head_select import mex_pkg::*; (
    input  mex_slot_stat_t [`MEX_Q_LENGTH-1:0] slots,
    input  logic [`MEX_PTR_WIDTH-1:0]          head_ptr,
    output mex_entry_t                         dout,
    output logic                               head_ready
);

    // slot currently at the head of the queue
    mex_slot_stat_t head;
    // every operand of the head has its value
    logic all_awake;

    // plain mux on the head pointer
    assign head = slots[head_ptr];

    // stale payload shows through when empty, head_ready stays low
    assign dout = head.entry;

    // and-reduce the wake vector
    assign all_awake = &head.entry.modif.wake;

    // ex may issue only when the head is real and fully woken
    assign head_ready = head.occupied && all_awake;

endmodule

/* mex_queued_latches.sv */
`timescale 1ns/1ps
`include "mex_settings.svh"

module mex_queued_latches import mex_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr,
    input  logic       rd,
    input  logic       clr,
    input  mex_entry_t din,
    input  mex_bcast_t bcast,
    output logic       full,
    output logic       empty,
    output mex_entry_t dout,
    output logic       head_ready
);

    // per-slot strobes from the controller
    logic [`MEX_Q_LENGTH-1:0] slot_wr;
    logic [`MEX_Q_LENGTH-1:0] slot_pop;
    logic slot_clr;
    logic [`MEX_PTR_WIDTH-1:0] head_ptr;
    // status of every slot toward the head mux
    mex_slot_stat_t [`MEX_Q_LENGTH-1:0] slot_stat;

    // pointers, count and strobes
    mex_queue_ctrl u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (wr),
        .rd       (rd),
        .clr      (clr),
        .full     (full),
        .empty    (empty),
        .slot_wr  (slot_wr),
        .slot_pop (slot_pop),
        .slot_clr (slot_clr),
        .head_ptr (head_ptr)
    );

    // one latch per queue position, all see din and bcast
    for (genvar i = 0; i < `MEX_Q_LENGTH; i++) begin : g_slot
        mex_latch_slot u_slot (
            .clk    (clk),
            .arst_n (arst_n),
            .wr_en  (slot_wr[i]),
            .pop    (slot_pop[i]),
            .clr    (slot_clr),
            .din    (din),
            .bcast  (bcast),
            .stat   (slot_stat[i])
        );
    end

    // oldest entry and its readiness
    mex_head_select u_head (
        .slots      (slot_stat),
        .head_ptr   (head_ptr),
        .dout       (dout),
        .head_ready (head_ready)
    );

endmodule

/* mex_assert.sv */
`timescale 1ns/1ps

module mex_assert (
    input logic clk,
    input logic arst_n,
    input logic clr,
    input logic full,
    input logic empty,
    input logic head_ready
);

    // number of assertion failures so far
    int fail_count = 0;

    // full and empty exclude each other
    property p_not_full_and_empty;
        @(posedge clk) disable iff (!arst_n)
            !(full && empty);
    endproperty

    // a ready head needs a real entry behind it
    property p_ready_not_empty;
        @(posedge clk) disable iff (!arst_n)
            head_ready |-> !empty;
    endproperty

    // clr wins over wr and leaves the queue empty on the next cycle
    property p_clr_empties;
        @(posedge clk) disable iff (!arst_n)
            clr |=> empty;
    endproperty

    a_not_full_and_empty: assert property (p_not_full_and_empty)
        else begin
            fail_count++;
            $error("full and empty are high together");
        end

    a_ready_not_empty: assert property (p_ready_not_empty)
        else begin
            fail_count++;
            $error("head_ready is high while the queue is empty");
        end

    a_clr_empties: assert property (p_clr_empties)
        else begin
            fail_count++;
            $error("queue is not empty one cycle after clr");
        end

endmodule

/* mex_tb.sv */
`timescale 1ns/1ps
`include "mex_settings.svh"

module mex_tb import mex_pkg::*; ();

    localparam int DEPTH = `MEX_Q_LENGTH;
    localparam int TW = `MEX_TAG_WIDTH;
    localparam int EW = $bits(mex_entry_t);
    localparam int EWORDS = (EW + 31) / 32;
    localparam int RANDOM_CYCLES = 400;
    // directed tests take well under 100 cycles and the random mix adds the rest
    localparam int MAX_CYCLES = 4 * (RANDOM_CYCLES + 100);
    localparam mex_bcast_t NO_BCAST = '0;

    logic       clk;
    logic       arst_n;
    logic       wr;
    logic       rd;
    logic       clr;
    mex_entry_t din;
    mex_bcast_t bcast;
    logic       full;
    logic       empty;
    mex_entry_t dout;
    logic       head_ready;

    int errors;
    int cycles;
    // reference queue, oldest entry at index 0
    mex_entry_t model_q[$];

    mex_queued_latches UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr         (wr),
        .rd         (rd),
        .clr        (clr),
        .din        (din),
        .bcast      (bcast),
        .full       (full),
        .empty      (empty),
        .dout       (dout),
        .head_ready (head_ready)
    );

    bind mex_queued_latches mex_assert u_assert (
        .clk        (clk),
        .arst_n     (arst_n),
        .clr        (clr),
        .full       (full),
        .empty      (empty),
        .head_ready (head_ready)
    );

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic compare_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            errors++;
            $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_entry(input string name, input mex_entry_t exp,
                                 input mex_entry_t act);
        assert (act === exp) else begin
            errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // reference wakeup of waiting operands with a matching tag and a valid result
    function automatic mex_entry_t apply_result(input mex_entry_t e, input mex_bcast_t b);
        mex_entry_t r;
        r = e;
        if (b.valid) begin
            for (int k = 0; k < `MEX_NUM_OPS; k++) begin
                if (r.modif.wake[k] == 1'b0 && r.fixed.src_tag[k] == b.tag) begin
                    r.modif.wake[k] = 1'b1;
                    r.modif.op_val[k] = b.value;
                end
            end
        end
        return r;
    endfunction

    function automatic mex_entry_t random_entry(input logic [`MEX_NUM_OPS-1:0] wake);
        logic [EWORDS*32-1:0] bits;
        mex_entry_t e;
        for (int k = 0; k < EWORDS; k++) begin
            bits[k*32 +: 32] = $urandom;
        end
        e = bits[EW-1:0];
        // small tag range so random broadcasts hit often
        for (int k = 0; k < `MEX_NUM_OPS; k++) begin
            e.fixed.src_tag[k] = TW'($urandom_range(0, 15));
        end
        e.modif.wake = wake;
        return e;
    endfunction

    function automatic mex_bcast_t make_bcast(input int tag, input logic [31:0] value);
        mex_bcast_t b;
        b.valid = 1'b1;
        b.tag = TW'(tag);
        b.value = value;
        return b;
    endfunction

    // next model state from the inputs seen at one clock edge
    task automatic model_step(input logic w, input logic r, input logic c,
                              input mex_entry_t d, input mex_bcast_t b);
        logic wr_ok;
        logic rd_ok;
        wr_ok = w && (model_q.size() < DEPTH);
        rd_ok = r && (model_q.size() > 0);
        if (c) begin
            model_q.delete();
        end else begin
            for (int i = 0; i < model_q.size(); i++) begin
                model_q[i] = apply_result(model_q[i], b);
            end
            if (rd_ok) begin
                void'(model_q.pop_front());
            end
            if (wr_ok) begin
                model_q.push_back(apply_result(d, b));
            end
        end
    endtask

    task automatic check_outputs();
        logic exp_ready;
        exp_ready = 1'b0;
        if (model_q.size() > 0) begin
            exp_ready = &model_q[0].modif.wake;
            // dout only means something with a real head
            compare_entry("dout", model_q[0], dout);
        end
        compare_bit("empty", model_q.size() == 0, empty);
        compare_bit("full", model_q.size() == DEPTH, full);
        compare_bit("head_ready", exp_ready, head_ready);
    endtask

    // called at a falling edge and returns at the next one after checking
    task automatic clock_step(input logic w, input logic r, input logic c,
                              input mex_entry_t d, input mex_bcast_t b);
        wr = w;
        rd = r;
        clr = c;
        din = d;
        bcast = b;
        model_step(w, r, c, d, b);
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic test_reset_state();
        compare_bit("empty", 1'b1, empty);
        compare_bit("full", 1'b0, full);
        compare_bit("head_ready", 1'b0, head_ready);
        clock_step(1'b0, 1'b0, 1'b0, '0, NO_BCAST);
    endtask

    task automatic test_fill_drain();
        mex_entry_t sent[`MEX_Q_LENGTH];
        mex_entry_t extra;
        for (int k = 0; k < DEPTH; k++) begin
            sent[k] = random_entry('1);
            clock_step(1'b1, 1'b0, 1'b0, sent[k], NO_BCAST);
        end
        compare_bit("full", 1'b1, full);
        extra = random_entry('1);
        clock_step(1'b1, 1'b0, 1'b0, extra, NO_BCAST);
        compare_bit("full", 1'b1, full);
        compare_entry("dout", sent[0], dout);
        // on a full queue wr and rd together only pop
        clock_step(1'b1, 1'b1, 1'b0, extra, NO_BCAST);
        compare_bit("full", 1'b0, full);
        for (int k = 1; k < DEPTH; k++) begin
            compare_entry("dout", sent[k], dout);
            clock_step(1'b0, 1'b1, 1'b0, '0, NO_BCAST);
        end
        compare_bit("empty", 1'b1, empty);
    endtask

    task automatic test_wakeup();
        mex_entry_t e0;
        mex_entry_t e1;
        mex_bcast_t b;
        e0 = random_entry('0);
        e1 = random_entry(4'b0001);
        for (int k = 0; k < `MEX_NUM_OPS; k++) begin
            e0.fixed.src_tag[k] = TW'(k + 1);
            e1.fixed.src_tag[k] = TW'(k + 8);
        end
        // op0 of e1 already awake and sharing tag 2 with e0 op1
        e1.fixed.src_tag[0] = TW'(2);
        e1.modif.op_val[0] = 32'h1111_0000;
        clock_step(1'b1, 1'b0, 1'b0, e0, NO_BCAST);
        clock_step(1'b1, 1'b0, 1'b0, e1, NO_BCAST);
        clock_step(1'b0, 1'b0, 1'b0, '0, make_bcast(40, 32'hdead_0040));
        compare_entry("dout", e0, dout);
        // matching tag but valid low
        b = make_bcast(1, 32'hdead_0001);
        b.valid = 1'b0;
        clock_step(1'b0, 1'b0, 1'b0, '0, b);
        compare_entry("dout", e0, dout);
        clock_step(1'b0, 1'b0, 1'b0, '0, make_bcast(2, 32'h2222_2222));
        compare_bit("dout.wake[1]", 1'b1, dout.modif.wake[1]);
        compare_word("dout.op_val[1]", 32'h2222_2222, dout.modif.op_val[1]);
        compare_bit("head_ready", 1'b0, head_ready);
        for (int t = 1; t <= 4; t++) begin
            clock_step(1'b0, 1'b0, 1'b0, '0, make_bcast(t, 32'h3000_0000 + t));
        end
        compare_bit("head_ready", 1'b1, head_ready);
        clock_step(1'b0, 1'b1, 1'b0, '0, NO_BCAST);
        // tag 2 must not have replaced an awake operand
        compare_word("dout.op_val[0]", 32'h1111_0000, dout.modif.op_val[0]);
        for (int t = 9; t <= 11; t++) begin
            clock_step(1'b0, 1'b0, 1'b0, '0, make_bcast(t, 32'h4000_0000 + t));
        end
        compare_bit("head_ready", 1'b1, head_ready);
        clock_step(1'b0, 1'b1, 1'b0, '0, NO_BCAST);
    endtask

    task automatic test_same_cycle_capture();
        mex_entry_t e;
        e = random_entry('0);
        for (int k = 0; k < `MEX_NUM_OPS; k++) begin
            e.fixed.src_tag[k] = TW'(k + 20);
        end
        e.fixed.src_tag[2] = TW'(7);
        clock_step(1'b1, 1'b0, 1'b0, e, make_bcast(7, 32'h7777_0007));
        compare_bit("dout.wake[2]", 1'b1, dout.modif.wake[2]);
        compare_word("dout.op_val[2]", 32'h7777_0007, dout.modif.op_val[2]);
        compare_bit("dout.wake[0]", 1'b0, dout.modif.wake[0]);
        clock_step(1'b0, 1'b1, 1'b0, '0, NO_BCAST);
    endtask

    task automatic test_clear();
        mex_entry_t a;
        mex_entry_t b;
        for (int k = 0; k < 5; k++) begin
            clock_step(1'b1, 1'b0, 1'b0, random_entry('1), NO_BCAST);
        end
        // clr beats a write and a read in the same cycle
        clock_step(1'b1, 1'b1, 1'b1, random_entry('1), NO_BCAST);
        compare_bit("empty", 1'b1, empty);
        compare_bit("full", 1'b0, full);
        compare_bit("head_ready", 1'b0, head_ready);
        a = random_entry('1);
        b = random_entry('1);
        clock_step(1'b1, 1'b0, 1'b0, a, NO_BCAST);
        clock_step(1'b1, 1'b0, 1'b0, b, NO_BCAST);
        compare_entry("dout", a, dout);
        clock_step(1'b0, 1'b1, 1'b0, '0, NO_BCAST);
        compare_entry("dout", b, dout);
        clock_step(1'b0, 1'b1, 1'b0, '0, NO_BCAST);
    endtask

    task automatic test_random_mix();
        logic w;
        logic r;
        logic c;
        mex_bcast_t b;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            w = ($urandom_range(0, 9) < 6);
            r = ($urandom_range(0, 9) < 5);
            c = ($urandom_range(0, 63) == 0);
            b = make_bcast($urandom_range(0, 15), $urandom);
            b.valid = ($urandom_range(0, 1) == 1);
            clock_step(w, r, c, random_entry(4'($urandom)), b);
        end
    endtask

    initial begin
        void'($urandom(32'h9c38));
        errors = 0;
        cycles = 0;
        clk = 1'b0;
        arst_n = 1'b0;
        wr = 1'b0;
        rd = 1'b0;
        clr = 1'b0;
        din = '0;
        bcast = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset_state();
        test_fill_drain();
        test_wakeup();
        test_same_cycle_capture();
        test_clear();
        test_random_mix();
        $display("checks done after %0d cycles, %0d errors, %0d assertion failures",
                 cycles, errors, UUT.u_assert.fail_count);
        if (errors == 0 && UUT.u_assert.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
mex_pkg.sv
mex_queue_ctrl.sv
mex_latch_slot.sv
mex_head_select.sv
mex_queued_latches.sv
mex_assert.sv
mex_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the mem to ex latch queue testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal --top-module mex_tb -f build.f -o mex_sim \
    > build.log 2>&1 &&
./obj_dir/mex_sim > sim.log 2>&1 ||
{ echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation finished: PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
